// File: project.f
src/mem_pkg.sv
src/mem_byte_shift.sv
src/mem_line_ram.sv
src/mem_line_buffer.sv
src/mem_bus_fsm.sv
src/mem_unit.sv
dv/tb_mem_unit.sv

// File: Bender.yml
package:
  name: mem_unit

sources:
  - src/mem_pkg.sv
  - src/mem_byte_shift.sv
  - src/mem_line_ram.sv
  - src/mem_line_buffer.sv
  - src/mem_bus_fsm.sv
  - src/mem_unit.sv
  - target: test
    files:
      - dv/tb_mem_unit.sv

// File: dv/tb_mem_unit.sv
// Testbench for the memory unit: bus master and arbiter model, line-array
// reference model and a table of write, read and idle transfers
`timescale 1ns/1ns
`default_nettype none

module tb_mem_unit import mem_pkg::*;
();

   localparam int MEM_LINES = 64;
   localparam int RESET_CYCLES = 10;
   localparam xfer_size_t EXP_SIZE = 12'd16;

   typedef enum logic [1:0] {OP_IDLE, OP_WRITE, OP_READ} op_t;

   logic     bus_clk;
   logic     rst_n;
   bus_req_t bus_in;
   logic     bg;
   logic     br;
   bus_drv_t bus_out;

   // Stimulus table, one column per field
   string      test_name[$];
   op_t        test_op[$];
   byte_addr_t test_addr[$];
   int         test_dly[$];
   block_t     test_data[$];

   line_t       ref_lines [MEM_LINES];
   logic [31:0] lcg_state = 32'h1cf4671f;
   int          errors = 0;
   int          cycle_cnt = 0;
   int          cycle_limit = 1000000;

   mem_unit #(
      .MEM_LINES (MEM_LINES)
   ) u_dut (
      .bus_clk (bus_clk),
      .rst_n   (rst_n),
      .bus_in  (bus_in),
      .bg      (bg),
      .br      (br),
      .bus_out (bus_out)
   );

   initial
   begin
      bus_clk = 1'b0;
      forever
         #20 bus_clk = ~bus_clk;
   end

   always @(posedge bus_clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit)
      begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Test FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic bus_req_t make_req(input logic sel, input logic rw,
                                         input byte_addr_t addr, input beat_t data);
      bus_req_t req;
      req.sel  = sel;
      req.rw   = rw;
      req.addr = addr;
      req.data = data;
      return req;
   endfunction

   // Line index is the address above bit 4, truncated to the depth
   function automatic int line_index(input byte_addr_t addr);
      return (int'(addr) >> 5) % MEM_LINES;
   endfunction

   function automatic block_t expected_read(input byte_addr_t addr);
      line_t  line;
      block_t half;
      block_t res;
      int     ofs;
      line = ref_lines[line_index(addr)];
      half = addr[4] ? line[255:128] : line[127:0];
      ofs  = int'(addr[3:0]);
      res  = '0;
      // Byte i takes byte i minus offset, lower bytes stay zero
      for (int i = ofs; i < 16; i++)
         res[8 * i +: 8] = half[8 * (i - ofs) +: 8];
      return res;
   endfunction

   task automatic add_entry(input string name, input op_t op, input byte_addr_t addr,
                            input int dly);
      block_t blk;
      blk = '0;
      if (op == OP_WRITE)
         for (int b = 0; b < 4; b++)
            blk[32 * b +: 32] = lcg_next();
      test_name.push_back(name);
      test_op.push_back(op);
      test_addr.push_back(addr);
      test_dly.push_back(dly);
      test_data.push_back(blk);
   endtask

   task automatic build_table();
      add_entry("quiet_after_reset", OP_IDLE,  16'h0000, 0);
      add_entry("wr_line3_lo",       OP_WRITE, 16'h0060, 0);
      add_entry("wr_line3_hi",       OP_WRITE, 16'h0070, 0);
      add_entry("rd_line3_lo",       OP_READ,  16'h0060, 0);
      add_entry("rd_line3_hi",       OP_READ,  16'h0070, 1);
      add_entry("wr_line10_lo",      OP_WRITE, 16'h0140, 0);
      add_entry("rd_ofs1",           OP_READ,  16'h0141, 0);
      add_entry("rd_ofs7",           OP_READ,  16'h0147, 2);
      add_entry("rd_ofs15",          OP_READ,  16'h014f, 0);
      add_entry("wr_line3_lo_again", OP_WRITE, 16'h0060, 0);
      add_entry("rd_line3_hi_intact",OP_READ,  16'h0070, 0);
      add_entry("rd_line3_lo_new",   OP_READ,  16'h0060, 0);
      add_entry("rd_grant_late",     OP_READ,  16'h0140, 6);
      add_entry("wr_line63_hi",      OP_WRITE, 16'h07f0, 0);
      add_entry("rd_line63_alias",   OP_READ,  16'h87f0, 3);
      add_entry("quiet_at_end",      OP_IDLE,  16'h0000, 0);
   endtask

   task automatic check_block(input string name, input block_t exp, input block_t act);
      if (act !== exp)
      begin
         errors++;
         $display("FAILED %s: block expected %h, got %h", name, exp, act);
      end
   endtask

   task automatic check_size(input string name, input xfer_size_t exp, input xfer_size_t act);
      if (act !== exp)
      begin
         errors++;
         $display("FAILED %s: size expected %0d, got %0d", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input string what, input logic exp,
                             input logic act);
      if (act !== exp)
      begin
         errors++;
         $display("FAILED %s: %s expected %b, got %b", name, what, exp, act);
      end
   endtask

   task automatic run_idle(input string name);
      repeat (8)
      begin
         @(negedge bus_clk);
         check_flag(name, "br", 1'b0, br);
         check_flag(name, "drive", 1'b0, bus_out.drive);
         check_flag(name, "ack", 1'b0, bus_out.ack);
      end
   endtask

   // Address cycle, four beats, then ack alone in the following cycle
   task automatic run_write(input string name, input byte_addr_t addr, input block_t blk);
      line_t line;
      @(posedge bus_clk);
      bus_in <= make_req(1'b1, 1'b1, addr, '0);
      for (int b = 0; b < 4; b++)
      begin
         @(posedge bus_clk);
         bus_in <= make_req(1'b0, 1'b1, addr, blk[32 * b +: 32]);
         @(negedge bus_clk);
         check_flag(name, "ack during beats", 1'b0, bus_out.ack);
      end
      @(posedge bus_clk);
      bus_in <= make_req(1'b0, 1'b0, '0, '0);
      @(negedge bus_clk);
      check_flag(name, "ack after fourth beat", 1'b1, bus_out.ack);
      check_flag(name, "drive with ack", 1'b0, bus_out.drive);
      @(negedge bus_clk);
      check_flag(name, "ack one cycle only", 1'b0, bus_out.ack);
      line = ref_lines[line_index(addr)];
      if (addr[4])
         line[255:128] = blk;
      else
         line[127:0] = blk;
      ref_lines[line_index(addr)] = line;
   endtask

   task automatic run_read(input string name, input byte_addr_t addr, input int dly);
      block_t got;
      block_t exp;
      exp = expected_read(addr);
      got = '0;
      @(posedge bus_clk);
      bus_in <= make_req(1'b1, 1'b0, addr, '0);
      @(posedge bus_clk);
      bus_in <= make_req(1'b0, 1'b0, '0, '0);
      @(negedge bus_clk);
      while (!br)
         @(negedge bus_clk);
      // Arbiter holds off the grant for the entry's delay
      for (int w = 0; w < dly; w++)
      begin
         @(negedge bus_clk);
         check_flag(name, "br while waiting", 1'b1, br);
         check_flag(name, "drive before grant", 1'b0, bus_out.drive);
      end
      @(posedge bus_clk);
      bg <= 1'b1;
      @(negedge bus_clk);
      while (!bus_out.drive)
         @(negedge bus_clk);
      for (int b = 0; b < 4; b++)
      begin
         if (b > 0)
            @(negedge bus_clk);
         check_flag(name, "drive", 1'b1, bus_out.drive);
         check_flag(name, "rw", 1'b1, bus_out.rw);
         check_flag(name, "br after grant", 1'b0, br);
         check_flag(name, "ack", b == 3, bus_out.ack);
         check_size(name, EXP_SIZE, bus_out.size);
         got[32 * b +: 32] = bus_out.data;
      end
      @(posedge bus_clk);
      bg <= 1'b0;
      @(negedge bus_clk);
      check_flag(name, "drive after last beat", 1'b0, bus_out.drive);
      check_flag(name, "ack after last beat", 1'b0, bus_out.ack);
      check_block(name, exp, got);
   endtask

   initial
   begin
      int max_dly;
      int err_before;
      int passed;
      int failed;
      max_dly = 0;
      passed  = 0;
      failed  = 0;
      rst_n   = 1'b0;
      bg      = 1'b0;
      bus_in  = '0;
      build_table();
      foreach (test_dly[i])
         if (test_dly[i] > max_dly)
            max_dly = test_dly[i];
      cycle_limit = test_name.size() * (12 + max_dly) + RESET_CYCLES;
      repeat (RESET_CYCLES)
         @(posedge bus_clk);
      rst_n <= 1'b1;
      for (int t = 0; t < test_name.size(); t++)
      begin
         err_before = errors;
         case (test_op[t])
            OP_WRITE: run_write(test_name[t], test_addr[t], test_data[t]);
            OP_READ:  run_read(test_name[t], test_addr[t], test_dly[t]);
            default:  run_idle(test_name[t]);
         endcase
         if (errors == err_before)
         begin
            passed++;
            $display("pass  %s", test_name[t]);
         end
         else
         begin
            failed++;
            $display("fail  %s (%0d mismatches)", test_name[t], errors - err_before);
         end
      end
      $display("%0d tests, %0d passed, %0d failed", passed + failed, passed, failed);
      if (failed == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: src/mem_unit.sv
// Memory unit top level: bus FSM, line buffers and line memory
`timescale 1ns/1ns
`default_nettype none

module mem_unit import mem_pkg::*;
#(
   parameter int MEM_LINES = 64
)
(
   input  logic     bus_clk,
   input  logic     rst_n,
   input  bus_req_t bus_in,
   input  logic     bg,
   output logic     br,
   output bus_drv_t bus_out
);

   mem_ctrl_t                    ctrl;
   logic [$clog2(MEM_LINES)-1:0] ram_index;
   logic                         ram_half;
   logic                         ram_we;
   logic                         ram_re;
   logic                         ack;
   byte_ofs_t                    shift_ofs;
   block_t                       wr_block;
   line_t                        ram_rdata;
   beat_t                        drive_data;

   mem_bus_fsm #(
      .MEM_LINES (MEM_LINES)
   ) u_fsm (
      .bus_clk   (bus_clk),
      .rst_n     (rst_n),
      .bus_in    (bus_in),
      .bg        (bg),
      .br        (br),
      .ctrl      (ctrl),
      .ram_index (ram_index),
      .ram_half  (ram_half),
      .ram_we    (ram_we),
      .ram_re    (ram_re),
      .ack       (ack),
      .shift_ofs (shift_ofs)
   );

   mem_line_buffer u_buf (
      .bus_clk    (bus_clk),
      .rst_n      (rst_n),
      .ctrl       (ctrl),
      .bus_data   (bus_in.data),
      .ram_rdata  (ram_rdata),
      .ram_half   (ram_half),
      .shift_ofs  (shift_ofs),
      .wr_block   (wr_block),
      .drive_data (drive_data)
   );

   mem_line_ram #(
      .MEM_LINES (MEM_LINES)
   ) u_ram (
      .bus_clk (bus_clk),
      .index   (ram_index),
      .half    (ram_half),
      .we      (ram_we),
      .re      (ram_re),
      .wdata   (wr_block),
      .rdata   (ram_rdata)
   );

   // Memory never starts a read, so rw is 1 whenever it drives
   assign bus_out.drive = ctrl.drive_beat;
   assign bus_out.data  = drive_data;
   assign bus_out.size  = ctrl.drive_beat ? BLOCK_BYTES : '0;
   assign bus_out.rw    = ctrl.drive_beat;
   assign bus_out.ack   = ack;

endmodule

`default_nettype wire

// File: src/mem_bus_fsm.sv
// Bus controller FSM with transfer size counter, registered br and ack,
// and the checks on the other bus agents
`timescale 1ns/1ns
`default_nettype none

module mem_bus_fsm import mem_pkg::*;
#(
   parameter int MEM_LINES = 64
)
(
   input  logic                         bus_clk,
   input  logic                         rst_n,
   input  bus_req_t                     bus_in,
   input  logic                         bg,
   output logic                         br,
   output mem_ctrl_t                    ctrl,
   output logic [$clog2(MEM_LINES)-1:0] ram_index,
   output logic                         ram_half,
   output logic                         ram_we,
   output logic                         ram_re,
   output logic                         ack,
   output byte_ofs_t                    shift_ofs
);

   localparam int IDX_W = $clog2(MEM_LINES);
   localparam xfer_size_t BEAT_BYTES = 12'd4;

   ctrl_state_t state_q;
   ctrl_state_t state_d;
   xfer_size_t  size_q;
   byte_addr_t  addr_q;
   logic        rw_q;
   logic        beat_step;
   logic        last_beat;
   logic        ack_d;

   // Transfer sequencing
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
            if (bus_in.sel)
               state_d = bus_in.rw ? SLV : ST_RD;
         SLV:
            if (last_beat)
               state_d = ST_WR;
         ST_WR:
            state_d = IDLE;
         ST_RD:
            state_d = ST_BR;
         ST_BR:
            if (bg)
               state_d = MSTR;
         MSTR:
            if (last_beat)
               state_d = IDLE;
         default:
            state_d = IDLE;
      endcase
   end

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= IDLE;
         addr_q  <= '0;
         rw_q    <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         // Address and direction only latch on a select seen in IDLE
         if (state_q == IDLE && bus_in.sel)
         begin
            addr_q <= bus_in.addr;
            rw_q   <= bus_in.rw;
         end
      end
   end

   // Size counts down 16, 12, 8, 4 while beats move
   assign beat_step = (state_q == SLV) || (state_q == MSTR);
   assign last_beat = (size_q == BEAT_BYTES);

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
         size_q <= '0;
      else if (state_q == IDLE && bus_in.sel)
         size_q <= BLOCK_BYTES;
      else if (beat_step)
         size_q <= size_q - BEAT_BYTES;
   end

   // Write ack lands in ST_WR, read ack on the fourth driven beat
   assign ack_d = (state_q == SLV && last_beat) ||
                  (state_q == MSTR && size_q == 2 * BEAT_BYTES);

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         br  <= 1'b0;
         ack <= 1'b0;
      end
      else
      begin
         br  <= (state_d == ST_BR);
         ack <= ack_d;
      end
   end

   always_comb
   begin
      ctrl.capture_beat = (state_q == SLV);
      // As the size falls the buffer lane rises
      ctrl.beat_idx     = beat_idx_t'((BLOCK_BYTES - size_q) >> 2);
      ctrl.load_rd      = (state_q == ST_BR);
      ctrl.drive_beat   = (state_q == MSTR);
   end

   assign ram_index = addr_q[5 +: IDX_W];
   assign ram_half  = addr_q[4];
   assign shift_ofs = addr_q[3:0];
   assign ram_we    = (state_q == ST_WR) && rw_q;
   assign ram_re    = (state_q == ST_RD) && !rw_q;

   // Bus agents may only select the unit while it is idle
   sel_only_in_idle: assert property (
      @(posedge bus_clk) disable iff (!rst_n)
      bus_in.sel |-> state_q == IDLE
   ) else $error("select received outside IDLE");

   // Writes always cover a whole aligned half-line
   write_aligned: assert property (
      @(posedge bus_clk) disable iff (!rst_n)
      (bus_in.sel && bus_in.rw) |-> bus_in.addr[3:0] == 4'h0
   ) else $error("write address has a nonzero byte offset");

endmodule

`default_nettype wire

// File: src/mem_line_buffer.sv
// Write block and read block buffers, read alignment shift
// and beat selection for the bus data lines
`timescale 1ns/1ns
`default_nettype none

module mem_line_buffer import mem_pkg::*;
(
   input  logic      bus_clk,
   input  logic      rst_n,
   input  mem_ctrl_t ctrl,
   input  beat_t     bus_data,
   input  line_t     ram_rdata,
   input  logic      ram_half,
   input  byte_ofs_t shift_ofs,
   output block_t    wr_block,
   output beat_t     drive_data
);

   block_t wr_block_q;
   block_t rd_block_q;
   block_t rd_half;
   block_t rd_shifted;

   // One 32-bit lane per captured beat, others hold
   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
         wr_block_q <= '0;
      else if (ctrl.capture_beat)
         wr_block_q[ctrl.beat_idx * 32 +: 32] <= bus_data;
   end

   assign wr_block = wr_block_q;

   // Pick the addressed half of the line
   assign rd_half = ram_half ? ram_rdata[255:128] : ram_rdata[127:0];

   mem_byte_shift u_shift
   (
      .din    (rd_half),
      .amount (shift_ofs),
      .dout   (rd_shifted)
   );

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
         rd_block_q <= '0;
      else if (ctrl.load_rd)
         rd_block_q <= rd_shifted;
   end

   // Data lines stay at zero when the unit does not own them
   always_comb
   begin
      if (ctrl.drive_beat)
         drive_data = rd_block_q[ctrl.beat_idx * 32 +: 32];
      else
         drive_data = '0;
   end

endmodule

`default_nettype wire

// File: src/mem_line_ram.sv
// Line memory, 256-bit lines, half-line writes and registered reads
`timescale 1ns/1ns
`default_nettype none

module mem_line_ram import mem_pkg::*;
#(
   parameter int MEM_LINES = 64
)
(
   input  logic                         bus_clk,
   input  logic [$clog2(MEM_LINES)-1:0] index,
   input  logic                         half,
   input  logic                         we,
   input  logic                         re,
   input  block_t                       wdata,
   output line_t                        rdata
);

   line_t lines [MEM_LINES];

   // Only the addressed half of the line changes
   always_ff @(posedge bus_clk)
   begin
      if (we)
      begin
         if (half)
            lines[index][255:128] <= wdata;
         else
            lines[index][127:0] <= wdata;
      end
   end

   // Whole line out one cycle after re, held otherwise
   always_ff @(posedge bus_clk)
   begin
      if (re)
         rdata <= lines[index];
   end

endmodule

`default_nettype wire

// File: src/mem_byte_shift.sv
// Byte left shifter for a 128-bit block, zero fill
`timescale 1ns/1ns
`default_nettype none

module mem_byte_shift import mem_pkg::*;
(
   input  block_t    din,
   input  byte_ofs_t amount,
   output block_t    dout
);

   block_t shifted [16];
   block_t level1 [4];

   // All sixteen candidate shifts
   for (genvar i = 0; i < 16; i++)
   begin : g_shift
      assign shifted[i] = din << (8 * i);
   end

   // First level picks within a group of four on amount[1:0]
   for (genvar j = 0; j < 4; j++)
   begin : g_level1
      assign level1[j] = shifted[4 * j + int'(amount[1:0])];
   end

   // Second level picks the group
   assign dout = level1[amount[3:2]];

endmodule

`default_nettype wire

// File: src/mem_pkg.sv
// Shared widths, bus request and drive structs, buffer control struct
// and the bus controller state encoding
`default_nettype none

package mem_pkg;

   typedef logic [15:0]  byte_addr_t;
   typedef logic [31:0]  beat_t;
   typedef logic [127:0] block_t;
   typedef logic [255:0] line_t;
   typedef logic [11:0]  xfer_size_t;
   typedef logic [1:0]   beat_idx_t;
   typedef logic [3:0]   byte_ofs_t;

   // Every transfer on the bus moves one 16-byte block
   localparam xfer_size_t BLOCK_BYTES = 12'd16;

   typedef struct packed {
      logic       sel;
      logic       rw;
      byte_addr_t addr;
      beat_t      data;
   } bus_req_t;

   typedef struct packed {
      logic       drive;
      beat_t      data;
      xfer_size_t size;
      logic       rw;
      logic       ack;
   } bus_drv_t;

   typedef struct packed {
      logic      capture_beat;
      beat_idx_t beat_idx;
      logic      load_rd;
      logic      drive_beat;
   } mem_ctrl_t;

   // One-hot state encoding
   typedef enum logic [5:0] {
      IDLE  = 6'b00_0001,
      ST_BR = 6'b00_0010,
      MSTR  = 6'b00_0100,
      ST_WR = 6'b00_1000,
      SLV   = 6'b01_0000,
      ST_RD = 6'b10_0000
   } ctrl_state_t;

endpackage

`default_nettype wire
